// ==== rename_core.f ====
+incdir+source
source/rename_pkg.sv
source/inst_buffer.sv
source/free_list.sv
source/rename_stage.sv
source/reorder_buffer.sv
source/rename_core.sv
testbench/rename_core_checker.sv
testbench/rename_core_tb.sv

// ==== source/free_list.sv ====
// Free list of physical registers.
// A circular FIFO of ROB_SZ register numbers. Reset loads it with the
// registers above the architectural range in ascending order, so the
// first renames get ARCH_REG_SZ, ARCH_REG_SZ+1 and so on. The rename
// stage takes from the head, the ROB puts retired t_old registers back
// at the tail.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    input  logic      take,           // head consumed by a dispatch
    input  logic      release_valid,  // retiring t_old comes back
    input  phys_reg_t release_preg,

    output phys_reg_t free_head
);

    localparam int PTR_W = $clog2(`ROB_SZ);

    phys_reg_t        regs [`ROB_SZ];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;     // next slot to refill

    //////////////////////////////
    // list contents
    //////////////////////////////

    // spare registers in ascending order after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++)
                regs[i] <= phys_reg_t'(`ARCH_REG_SZ + i);
        end else if (release_valid) begin
            regs[tail_ptr] <= release_preg;
        end
    end

    //////////////////////////////
    // pointers
    //////////////////////////////

    // starts full with head and tail both at slot 0
    // never holds more than ROB_SZ registers and never runs dry
    // while the ROB has room
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (take)
                head_ptr <= head_ptr + 1'b1;
            if (release_valid)
                tail_ptr <= tail_ptr + 1'b1;
        end
    end

    assign free_head = regs[head_ptr];

endmodule

// ==== source/inst_buffer.sv ====
// Instruction buffer in front of the rename stage.
// Holds up to IB_DEPTH decoded instructions in arrival order. The
// upstream sender owns IB_DEPTH credits after reset and spends one per
// write, so there is no full flag. Each pop hands a credit back one
// cycle later on in_credit.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module inst_buffer import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // upstream write side
    input  logic      in_valid,
    input  logic      in_has_dest,
    input  arch_reg_t in_dest,
    input  arch_reg_t in_src1,
    input  arch_reg_t in_src2,

    // head towards rename
    input  logic      pop,
    output logic      head_valid,
    output logic      head_has_dest,
    output arch_reg_t head_dest,
    output arch_reg_t head_src1,
    output arch_reg_t head_src2,

    output logic      in_credit     // one pulse per popped entry
);

    localparam int PTR_W = $clog2(`IB_DEPTH);

    // entry payload
    logic      buf_has_dest [`IB_DEPTH];
    arch_reg_t buf_dest     [`IB_DEPTH];
    arch_reg_t buf_src1     [`IB_DEPTH];
    arch_reg_t buf_src2     [`IB_DEPTH];

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    credit_cnt_t      count;        // entries held, never above IB_DEPTH

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (in_valid) begin
            buf_has_dest[tail_ptr] <= in_has_dest;
            buf_dest[tail_ptr]     <= in_dest;
            buf_src1[tail_ptr]     <= in_src1;
            buf_src2[tail_ptr]     <= in_src2;
        end
    end

    //////////////////////////////
    // pointers and credit return
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid)
                tail_ptr <= tail_ptr + 1'b1;   // wraps, depth is a power of two
            if (pop)
                head_ptr <= head_ptr + 1'b1;
            count     <= count + credit_cnt_t'(in_valid) - credit_cnt_t'(pop);
            in_credit <= pop;                  // slot freed, give it back
        end
    end

    assign head_valid    = (count != '0);
    assign head_has_dest = buf_has_dest[head_ptr];
    assign head_dest     = buf_dest[head_ptr];
    assign head_src1     = buf_src1[head_ptr];
    assign head_src2     = buf_src2[head_ptr];

endmodule

// ==== source/rename_core.sv ====
// Top level of the rename core.
// Instruction buffer, rename stage with free list, and reorder buffer.
// Upstream and commit ports are credit controlled, completions come in
// by ROB tag, and each dispatch is visible on the disp_* outputs.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module rename_core (
    input  logic                             clock,
    input  logic                             reset,
    // upstream
    input  logic                             in_valid,
    input  logic                             in_has_dest,
    input  logic [$clog2(`ARCH_REG_SZ)-1:0]  in_dest,
    input  logic [$clog2(`ARCH_REG_SZ)-1:0]  in_src1,
    input  logic [$clog2(`ARCH_REG_SZ)-1:0]  in_src2,
    output logic                             in_credit,
    // completion
    input  logic                             complete_valid,
    input  logic [$clog2(`ROB_SZ)-1:0]       complete_tag,
    // commit
    input  logic                             commit_credit,
    output logic                             commit_valid,
    output logic [$clog2(`ROB_SZ)-1:0]       commit_tag,
    output logic [$clog2(`ARCH_REG_SZ)-1:0]  commit_arch,
    output logic [$clog2(`PHYS_REG_SZ)-1:0]  commit_preg,
    // dispatch observation
    output logic                             disp_valid,
    output logic [$clog2(`ROB_SZ)-1:0]       disp_tag,
    output logic [$clog2(`PHYS_REG_SZ)-1:0]  disp_dest_preg,
    output logic [$clog2(`PHYS_REG_SZ)-1:0]  disp_src1_preg,
    output logic [$clog2(`PHYS_REG_SZ)-1:0]  disp_src2_preg
);

    // buffer head
    logic                            head_valid, head_has_dest, pop;
    logic [$clog2(`ARCH_REG_SZ)-1:0] head_dest, head_src1, head_src2;

    // rename to ROB and back
    logic                            alloc, alloc_has_dest, rob_full, release_valid;
    logic [$clog2(`ARCH_REG_SZ)-1:0] alloc_arch;
    logic [$clog2(`PHYS_REG_SZ)-1:0] alloc_preg, alloc_told, release_preg;
    logic [$clog2(`ROB_SZ)-1:0]      alloc_tag;

    inst_buffer i_inst_buffer (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_has_dest(in_has_dest),
        .in_dest(in_dest), .in_src1(in_src1), .in_src2(in_src2),
        .pop(pop), .head_valid(head_valid), .head_has_dest(head_has_dest),
        .head_dest(head_dest), .head_src1(head_src1), .head_src2(head_src2),
        .in_credit(in_credit)
    );

    rename_stage i_rename_stage (
        .clock(clock), .reset(reset),
        .head_valid(head_valid), .head_has_dest(head_has_dest),
        .head_dest(head_dest), .head_src1(head_src1), .head_src2(head_src2),
        .pop(pop), .rob_full(rob_full), .alloc_tag(alloc_tag),
        .release_valid(release_valid), .release_preg(release_preg),
        .alloc(alloc), .alloc_arch(alloc_arch), .alloc_preg(alloc_preg),
        .alloc_told(alloc_told), .alloc_has_dest(alloc_has_dest),
        .disp_valid(disp_valid), .disp_tag(disp_tag), .disp_dest_preg(disp_dest_preg),
        .disp_src1_preg(disp_src1_preg), .disp_src2_preg(disp_src2_preg)
    );

    reorder_buffer i_reorder_buffer (
        .clock(clock), .reset(reset),
        .alloc(alloc), .alloc_arch(alloc_arch), .alloc_preg(alloc_preg),
        .alloc_told(alloc_told), .alloc_has_dest(alloc_has_dest),
        .rob_full(rob_full), .alloc_tag(alloc_tag),
        .complete_valid(complete_valid), .complete_tag(complete_tag),
        .release_valid(release_valid), .release_preg(release_preg),
        .commit_credit(commit_credit), .commit_valid(commit_valid),
        .commit_tag(commit_tag), .commit_arch(commit_arch), .commit_preg(commit_preg)
    );

endmodule

// ==== source/rename_core_consts.svh ====
// Size constants for the rename core.
// Register file sizes, reorder buffer depth, instruction buffer depth
// and credit counter width. Include in any file that sizes an array
// or a counter from these values.

`ifndef RENAME_CORE_CONSTS_SVH
`define RENAME_CORE_CONSTS_SVH

//////////////////////////////
// register files
//////////////////////////////

`define ARCH_REG_SZ   8     // architectural registers
`define PHYS_REG_SZ   16    // physical registers

//////////////////////////////
// queues
//////////////////////////////

// ROB_SZ has to equal PHYS_REG_SZ - ARCH_REG_SZ, so the free list
// always has a register for any instruction the ROB can accept
`define ROB_SZ        8
`define IB_DEPTH      4     // also the upstream credits after reset

`define CREDIT_CNT_W  4     // wide enough for IB_DEPTH and commit credits

`endif

// ==== source/rename_pkg.sv ====
// Width types shared by the rename core RTL and its checker.
// Import with rename_pkg::* in the module header.

`include "rename_core_consts.svh"

package rename_pkg;

    //////////////////////////////
    // register numbers
    //////////////////////////////

    // architectural register index
    typedef logic [$clog2(`ARCH_REG_SZ)-1:0] arch_reg_t;

    // physical register index
    typedef logic [$clog2(`PHYS_REG_SZ)-1:0] phys_reg_t;

    //////////////////////////////
    // queue indices and counters
    //////////////////////////////

    typedef logic [$clog2(`ROB_SZ)-1:0] rob_tag_t;    // ROB slot, also the tag

    // credit counters on both flow-controlled ports
    typedef logic [`CREDIT_CNT_W-1:0] credit_cnt_t;

endpackage

// ==== source/rename_stage.sv ====
// Register rename stage.
// Holds the map table from architectural to physical registers and
// owns the free list. Each cycle it looks at the instruction buffer
// head, and dispatches it if the ROB has room. Sources are looked up,
// the old destination mapping goes to the ROB as t_old, and the free
// list head becomes the new destination. All dispatch outputs are
// combinational; the map and free list move at the closing edge.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module rename_stage import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    // instruction buffer head
    input  logic      head_valid,
    input  logic      head_has_dest,
    input  arch_reg_t head_dest,
    input  arch_reg_t head_src1,
    input  arch_reg_t head_src2,
    output logic      pop,

    // reorder buffer
    input  logic      rob_full,
    input  rob_tag_t  alloc_tag,
    input  logic      release_valid,  // t_old from a retiring instruction
    input  phys_reg_t release_preg,
    output logic      alloc,
    output arch_reg_t alloc_arch,
    output phys_reg_t alloc_preg,
    output phys_reg_t alloc_told,
    output logic      alloc_has_dest,

    // dispatch observation
    output logic      disp_valid,
    output rob_tag_t  disp_tag,
    output phys_reg_t disp_dest_preg,
    output phys_reg_t disp_src1_preg,
    output phys_reg_t disp_src2_preg
);

    phys_reg_t map_table [`ARCH_REG_SZ];

    logic      dispatch;
    logic      take;
    phys_reg_t free_head;
    phys_reg_t new_preg;

    //////////////////////////////
    // dispatch decision
    //////////////////////////////

    assign dispatch = head_valid && !rob_full;
    assign take     = dispatch && head_has_dest;   // no-dest instrs keep the list

    assign pop        = dispatch;
    assign alloc      = dispatch;
    assign disp_valid = dispatch;
    assign disp_tag   = alloc_tag;                 // tag is the ROB tail slot

    //////////////////////////////
    // rename
    //////////////////////////////

    assign new_preg = head_has_dest ? free_head : '0;

    assign disp_src1_preg = map_table[head_src1];
    assign disp_src2_preg = map_table[head_src2];
    assign disp_dest_preg = new_preg;

    assign alloc_preg     = new_preg;
    assign alloc_arch     = head_has_dest ? head_dest : '0;
    assign alloc_told     = head_has_dest ? map_table[head_dest] : '0;
    assign alloc_has_dest = head_has_dest;

    // identity mapping after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++)
                map_table[i] <= phys_reg_t'(i);
        end else if (take) begin
            map_table[head_dest] <= free_head;
        end
    end

    //////////////////////////////
    // free list
    //////////////////////////////

    free_list i_free_list (
        .clock         (clock),
        .reset         (reset),
        .take          (take),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .free_head     (free_head)
    );

endmodule

// ==== source/reorder_buffer.sv ====
// Reorder buffer.
// A circular table of ROB_SZ entries, allocated at the tail by the
// rename stage and retired in order from the head. Completions arrive
// by tag from outside and mark an entry done; tags that are not in
// flight are dropped. The head retires once it is done and the
// downstream has granted a commit credit. A retiring entry with a
// destination hands its t_old back to the free list.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // allocation from rename
    input  logic        alloc,
    input  arch_reg_t   alloc_arch,
    input  phys_reg_t   alloc_preg,
    input  phys_reg_t   alloc_told,
    input  logic        alloc_has_dest,
    output logic        rob_full,
    output rob_tag_t    alloc_tag,

    // completion
    input  logic        complete_valid,
    input  rob_tag_t    complete_tag,

    // register return to the free list
    output logic        release_valid,
    output phys_reg_t   release_preg,

    // commit port
    input  logic        commit_credit,
    output logic        commit_valid,
    output rob_tag_t    commit_tag,
    output arch_reg_t   commit_arch,
    output phys_reg_t   commit_preg
);

    // payload per entry
    arch_reg_t  ent_arch     [`ROB_SZ];
    phys_reg_t  ent_preg     [`ROB_SZ];
    phys_reg_t  ent_told     [`ROB_SZ];
    logic       ent_has_dest [`ROB_SZ];

    logic [`ROB_SZ-1:0] ent_valid;     // in flight
    logic [`ROB_SZ-1:0] ent_done;

    rob_tag_t    head;
    rob_tag_t    tail;
    credit_cnt_t commit_credits;
    logic        retire;

    //////////////////////////////
    // allocation
    //////////////////////////////

    assign rob_full  = ent_valid[tail];    // tail caught up with head
    assign alloc_tag = tail;

    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_arch[tail]     <= alloc_arch;
            ent_preg[tail]     <= alloc_preg;
            ent_told[tail]     <= alloc_told;
            ent_has_dest[tail] <= alloc_has_dest;
        end
    end

    //////////////////////////////
    // status bits and pointers
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid      <= '0;
            ent_done       <= '0;
            head           <= '0;
            tail           <= '0;
            commit_credits <= '0;
        end else begin
            if (complete_valid && ent_valid[complete_tag])
                ent_done[complete_tag] <= 1'b1;   // stray tags ignored
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            // alloc never hits the retiring slot since the ROB is not full then
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= tail + 1'b1;
            end
            commit_credits <= commit_credits + credit_cnt_t'(commit_credit)
                              - credit_cnt_t'(retire);
        end
    end

    //////////////////////////////
    // retirement
    //////////////////////////////

    assign retire = ent_valid[head] && ent_done[head] && (commit_credits != '0);

    assign commit_valid = retire;
    assign commit_tag   = head;
    assign commit_arch  = ent_arch[head];
    assign commit_preg  = ent_preg[head];

    assign release_valid = retire && ent_has_dest[head];
    assign release_preg  = ent_told[head];

endmodule

// ==== testbench/rename_core_checker.sv ====
// Assertion module bound into rename_core.
// Keeps a shadow instruction buffer, map table, free list and per-tag
// record, all updated from port events, and checks the DUT against them.
// error_count counts failed assertions for the testbench summary.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module rename_core_checker import rename_pkg::*; (
    input logic      clock,
    input logic      reset,
    input logic      in_valid,
    input logic      in_has_dest,
    input arch_reg_t in_dest,
    input arch_reg_t in_src1,
    input arch_reg_t in_src2,
    input logic      in_credit,
    input logic      commit_credit,
    input logic      commit_valid,
    input rob_tag_t  commit_tag,
    input arch_reg_t commit_arch,
    input phys_reg_t commit_preg,
    input logic      disp_valid,
    input rob_tag_t  disp_tag,
    input phys_reg_t disp_dest_preg,
    input phys_reg_t disp_src1_preg,
    input phys_reg_t disp_src2_preg
);

    int error_count = 0;

    // shadow instruction buffer
    logic      ib_has  [`IB_DEPTH];
    arch_reg_t ib_dest [`IB_DEPTH];
    arch_reg_t ib_src1 [`IB_DEPTH];
    arch_reg_t ib_src2 [`IB_DEPTH];
    logic [$clog2(`IB_DEPTH)-1:0] ib_head, ib_tail;
    int        ib_count;

    // shadow rename state
    phys_reg_t map     [`ARCH_REG_SZ];
    phys_reg_t fl      [`ROB_SZ];
    rob_tag_t  fl_head, fl_tail;     // same width as a ROB index
    arch_reg_t tag_arch [`ROB_SZ];
    phys_reg_t tag_preg [`ROB_SZ];
    phys_reg_t tag_told [`ROB_SZ];
    logic      tag_has  [`ROB_SZ];
    rob_tag_t  exp_tag, exp_commit;
    int        outstanding, dispatched, returned, down_credits;

    phys_reg_t exp_dest, exp_src1, exp_src2, exp_told;

    always_comb begin
        exp_src1 = map[ib_src1[ib_head]];
        exp_src2 = map[ib_src2[ib_head]];
        exp_dest = ib_has[ib_head] ? fl[fl_head] : '0;
        exp_told = ib_has[ib_head] ? map[ib_dest[ib_head]] : '0;
    end

    //////////////////////////////
    // shadow update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_SZ; i++)
                map[i] <= phys_reg_t'(i);        // identity
            for (int i = 0; i < `ROB_SZ; i++)
                fl[i] <= phys_reg_t'(`ARCH_REG_SZ + i);
            fl_head      <= '0;
            fl_tail      <= '0;
            ib_head      <= '0;
            ib_tail      <= '0;
            ib_count     <= 0;
            exp_tag      <= '0;
            exp_commit   <= '0;
            outstanding  <= 0;
            dispatched   <= 0;
            returned     <= 0;
            down_credits <= 0;
        end else begin
            if (in_valid) begin
                ib_has[ib_tail]  <= in_has_dest;
                ib_dest[ib_tail] <= in_dest;
                ib_src1[ib_tail] <= in_src1;
                ib_src2[ib_tail] <= in_src2;
                ib_tail          <= ib_tail + 1'b1;
            end
            if (disp_valid) begin
                ib_head           <= ib_head + 1'b1;
                tag_has[exp_tag]  <= ib_has[ib_head];
                tag_arch[exp_tag] <= ib_has[ib_head] ? ib_dest[ib_head] : '0;
                tag_preg[exp_tag] <= exp_dest;
                tag_told[exp_tag] <= exp_told;
                exp_tag           <= exp_tag + 1'b1;
                if (ib_has[ib_head]) begin
                    map[ib_dest[ib_head]] <= fl[fl_head];
                    fl_head               <= fl_head + 1'b1;
                end
            end
            if (commit_valid) begin
                exp_commit <= exp_commit + 1'b1;
                if (tag_has[exp_commit]) begin   // freed in retire order
                    fl[fl_tail] <= tag_told[exp_commit];
                    fl_tail     <= fl_tail + 1'b1;
                end
            end
            ib_count     <= ib_count + int'(in_valid) - int'(disp_valid);
            outstanding  <= outstanding + int'(disp_valid) - int'(commit_valid);
            dispatched   <= dispatched + int'(disp_valid);
            returned     <= returned + int'(in_credit);
            down_credits <= down_credits + int'(commit_credit) - int'(commit_valid);
        end
    end

    //////////////////////////////
    // assertions
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clock) $past(reset) && !reset
        |-> !disp_valid && !commit_valid && !in_credit)
        else begin
            $error("outputs not idle right after reset");
            error_count++;
        end

    a_disp_dest: assert property (@(posedge clock) disable iff (reset)
        disp_valid |-> disp_dest_preg == exp_dest)
        else begin
            $error("ERROR t=%0t disp_dest_preg got %0d expected %0d", $time,
                   $sampled(disp_dest_preg), $sampled(exp_dest));
            error_count++;
        end

    a_disp_tag: assert property (@(posedge clock) disable iff (reset)
        disp_valid |-> disp_tag == exp_tag)
        else begin
            $error("ERROR t=%0t disp_tag got %0d expected %0d", $time,
                   $sampled(disp_tag), $sampled(exp_tag));
            error_count++;
        end

    a_disp_srcs: assert property (@(posedge clock) disable iff (reset)
        disp_valid |-> disp_src1_preg == exp_src1 && disp_src2_preg == exp_src2)
        else begin
            $error("ERROR t=%0t disp_src1_preg/disp_src2_preg got %0d/%0d expected %0d/%0d",
                   $time, $sampled(disp_src1_preg), $sampled(disp_src2_preg),
                   $sampled(exp_src1), $sampled(exp_src2));
            error_count++;
        end

    a_commit_order: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> commit_tag == exp_commit && commit_preg == tag_preg[exp_commit])
        else begin
            $error("ERROR t=%0t commit_tag/commit_preg got %0d/%0d expected %0d/%0d", $time,
                   $sampled(commit_tag), $sampled(commit_preg),
                   $sampled(exp_commit), $sampled(tag_preg[exp_commit]));
            error_count++;
        end

    a_commit_arch: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> commit_arch == tag_arch[exp_commit])
        else begin
            $error("ERROR t=%0t commit_arch got %0d expected %0d", $time,
                   $sampled(commit_arch), $sampled(tag_arch[exp_commit]));
            error_count++;
        end

    a_rob_bound: assert property (@(posedge clock) disable iff (reset)
        disp_valid |-> outstanding < `ROB_SZ && ib_count != 0)
        else begin
            $error("dispatch with a full ROB or an empty instruction buffer");
            error_count++;
        end

    a_credit_return: assert property (@(posedge clock) disable iff (reset)
        in_credit |-> returned < dispatched)
        else begin
            $error("more upstream credits returned than instructions dispatched");
            error_count++;
        end

    a_commit_credit: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> down_credits != 0)
        else begin
            $error("commit without a downstream credit");
            error_count++;
        end

endmodule

bind rename_core rename_core_checker i_checker (.*);

// ==== testbench/rename_core_tb.sv ====
// Testbench for the rename core.
// Sends random instructions under upstream credits, completes ROB tags
// in random order and grants commit credits at random, over five phases.
// The bound checker does the checking; this module drives and reports.

`timescale 1ns/10ps

`include "rename_core_consts.svh"

module rename_core_tb;

    localparam int MAX_CYCLES = 5 * 200 * 3;   // 5 phases of up to 200 instrs at 3 cycles

    logic clock;
    logic reset;
    logic in_valid, in_has_dest, in_credit;
    logic [$clog2(`ARCH_REG_SZ)-1:0] in_dest, in_src1, in_src2, commit_arch;
    logic complete_valid, commit_credit, commit_valid, disp_valid;
    logic [$clog2(`ROB_SZ)-1:0] complete_tag, commit_tag, disp_tag;
    logic [$clog2(`PHYS_REG_SZ)-1:0] commit_preg, disp_dest_preg;
    logic [$clog2(`PHYS_REG_SZ)-1:0] disp_src1_preg, disp_src2_preg;

    int up_credits;           // upstream credits held
    int held;                 // commit credits granted, not yet used
    int total_sent;
    int commits;
    int phases;
    int cycle_count;
    int tags[$];              // dispatched, not yet completed

    rename_core i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d committed",
                     cycle_count, commits, total_sent);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////
    // one traffic phase
    //////////////////////////////

    task automatic run_phase(input string name, input int n, input int send_pct,
                             input int comp_pct, input int cred_pct,
                             input bit fill_first, input int credit_hold);
        int sent;
        int cyc;
        int idx;
        bit comp_open;
        sent = 0;
        cyc = 0;
        comp_open = !fill_first;
        while (sent < n || commits < total_sent) begin
            @(negedge clock);
            cyc++;
            if (in_credit)
                up_credits++;
            if (commit_valid) begin
                commits++;
                held--;
            end
            in_valid = 1'b0;
            complete_valid = 1'b0;
            commit_credit = 1'b0;
            if (tags.size() >= `ROB_SZ)
                comp_open = 1'b1;            // ROB is full so completions may start
            // pick before queueing this cycle's tag, which is not in flight yet
            if (comp_open && tags.size() > 0 && $urandom_range(99) < comp_pct) begin
                idx = $urandom_range(tags.size() - 1);
                complete_tag = tags[idx];
                complete_valid = 1'b1;
                tags.delete(idx);
            end
            if (disp_valid)
                tags.push_back(disp_tag);
            if (cyc > credit_hold && held < `ROB_SZ && $urandom_range(99) < cred_pct) begin
                commit_credit = 1'b1;
                held++;
            end
            if (sent < n && up_credits > 0 && $urandom_range(99) < send_pct) begin
                in_valid = 1'b1;
                in_has_dest = ($urandom_range(3) != 0);
                in_dest = $urandom_range(`ARCH_REG_SZ - 1);
                in_src1 = $urandom_range(`ARCH_REG_SZ - 1);
                in_src2 = $urandom_range(`ARCH_REG_SZ - 1);
                up_credits--;
                sent++;
                total_sent++;
            end
        end
        phases++;
        $display("phase %s done: %0d instructions in %0d cycles", name, n, cyc);
    endtask

    initial begin
        void'($urandom(32'h001d_5066));
        reset = 1'b1;
        in_valid = 1'b0;
        in_has_dest = 1'b0;
        in_dest = '0;
        in_src1 = '0;
        in_src2 = '0;
        complete_valid = 1'b0;
        complete_tag = '0;
        commit_credit = 1'b0;
        up_credits = `IB_DEPTH;
        held = 0;
        total_sent = 0;
        commits = 0;
        phases = 0;
        cycle_count = 0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        run_phase("random", 150, 70, 50, 50, 1'b0, 0);
        run_phase("rob_fill", 60, 90, 60, 60, 1'b1, 0);
        run_phase("no_commit_credit", 60, 90, 70, 60, 1'b0, 100);
        run_phase("dense", 200, 95, 90, 90, 1'b0, 0);
        run_phase("sparse", 100, 50, 50, 50, 1'b0, 0);

        $display("%0d phases, %0d dispatched, %0d committed, %0d assertion failures",
                 phases, total_sent, commits, i_dut.i_checker.error_count);
        if (i_dut.i_checker.error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
